// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --assert --timing
TOP       = dcache_tb
RTL_TOP   = dcache_top
FILELIST  = dcache_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TEST RESULT: FAIL
PASS_MSG  = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dcache_top.f ====
src/dcache_pkg.sv
src/dcache_ctrl.sv
src/dcache_tag_store.sv
src/dcache_data_store.sv
src/dcache_top.sv
dv/dcache_tb_mem.sv
dv/dcache_tb.sv

// ==== dv/dcache_tb.sv ====
// one request at a time; test addresses stay below 64 blocks, the memory model's size
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;
	import dcache_pkg::*;

	localparam int SET_BITS   = 2;
	localparam int NUM_SETS   = 1 << SET_BITS;
	localparam int MEM_BLOCKS = 64;
	localparam int MEM_WORDS  = MEM_BLOCKS * WORDS_PER_BLOCK;
	localparam int N_RANDOM   = 400;
	// 400 ops at about 20 cycles each, directed part on top
	localparam int MAX_CYCLES = 10000;

	logic        clk = 1'b0;
	logic        proc_reset;
	proc_req_t   proc_req;
	word_t       proc_rdata;
	logic        proc_stall;
	mem_req_t    mem_req;
	block_t      mem_rdata;
	logic        mem_ready;
	logic        wb_valid;
	block_addr_t wb_addr;
	block_t      wb_block;
	int          seed = 21;
	int          cycle_cnt = 0;

	// shadow memory and shadow tags, LRU names the victim way
	word_t       shadow    [MEM_WORDS];
	block_addr_t ref_blk   [NUM_WAYS][NUM_SETS];
	logic        ref_valid [NUM_WAYS][NUM_SETS];
	logic        ref_dirty [NUM_WAYS][NUM_SETS];
	logic        ref_lru   [NUM_SETS];

	// memory traffic seen since the last op
	logic        ev_write_q [$];
	block_addr_t ev_addr_q  [$];
	block_addr_t wb_addr_q  [$];
	block_t      wb_block_q [$];
	logic        prev_read;
	logic        prev_write;

	dcache_top #(.SET_BITS(SET_BITS)) dcache_top_i (
		.clk(clk), .proc_reset(proc_reset), .proc_req(proc_req), .proc_rdata(proc_rdata),
		.proc_stall(proc_stall), .mem_req(mem_req), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
	);

	dcache_tb_mem #(.MEM_BLOCKS(MEM_BLOCKS), .SEED(21)) mem_i (
		.clk(clk), .proc_reset(proc_reset), .mem_req(mem_req), .mem_rdata(mem_rdata),
		.mem_ready(mem_ready), .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_block(wb_block)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("simulation timed out after %0d cycles", cycle_cnt);
			stop_with_failure();
		end
	end

	// ------------------------------
	// traffic monitor
	// ------------------------------
	// strobe rising edges give request order
	always @(posedge clk) begin
		if (proc_reset) begin
			prev_read  = 1'b0;
			prev_write = 1'b0;
		end else begin
			if (mem_req.read && !prev_read) begin
				ev_write_q.push_back(1'b0);
				ev_addr_q.push_back(mem_req.addr);
			end
			if (mem_req.write && !prev_write) begin
				ev_write_q.push_back(1'b1);
				ev_addr_q.push_back(mem_req.addr);
			end
			if (wb_valid) begin
				wb_addr_q.push_back(wb_addr);
				wb_block_q.push_back(wb_block);
			end
			prev_read  = mem_req.read;
			prev_write = mem_req.write;
		end
	end

	task automatic stop_with_failure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_block(input block_t got, input block_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_addr(input block_addr_t got, input block_addr_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	// odd multiplier spreads every address bit over the word
	function automatic word_t init_word(int unsigned a);
		return (a * 32'h9E37_79B9) ^ 32'h0F1E_2D3C;
	endfunction

	function automatic block_t init_block(int b);
		block_t blk;
		for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
			blk[i*WORD_W +: WORD_W] = init_word(b * WORDS_PER_BLOCK + i);
		end
		return blk;
	endfunction

	function automatic word_t expected_word(word_addr_t a);
		return shadow[int'(a)];
	endfunction

	// word 0 in the low bits
	function automatic block_t shadow_block(block_addr_t b);
		block_t blk;
		for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
			blk[i*WORD_W +: WORD_W] = shadow[(int'(b) << WORD_OFS_W) + i];
		end
		return blk;
	endfunction

	// hit or miss, victim and dirty eviction, then the same update as the cache
	task automatic predict_access(input word_addr_t a, input logic wr, output logic miss,
		output logic wb, output block_addr_t victim);
		block_addr_t blk;
		int          s;
		int          way;
		blk    = a[WORD_ADDR_W-1:WORD_OFS_W];
		s      = int'(blk) % NUM_SETS;
		miss   = 1'b1;
		wb     = 1'b0;
		victim = '0;
		way    = 0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (ref_valid[w][s] && ref_blk[w][s] == blk) begin
				miss = 1'b0;
				way  = w;
			end
		end
		if (miss) begin
			way              = int'(ref_lru[s]);
			wb               = ref_valid[way][s] && ref_dirty[way][s];
			victim           = ref_blk[way][s];
			ref_blk[way][s]  = blk;
			ref_valid[way][s] = 1'b1;
			ref_dirty[way][s] = 1'b0;
		end
		// other way becomes the victim
		ref_lru[s] = (way == 0);
		if (wr) begin
			ref_dirty[way][s] = 1'b1;
		end
	endtask

	// ------------------------------
	// one processor access
	// ------------------------------
	task automatic run_op(input logic wr, input word_addr_t a, input word_t d);
		logic        exp_miss;
		logic        exp_wb;
		block_addr_t victim;
		block_t      victim_data;
		logic        stalled;
		word_t       got;
		int          exp_n;
		predict_access(a, wr, exp_miss, exp_wb, victim);
		victim_data = shadow_block(victim);
		exp_n       = int'(exp_miss) + int'(exp_wb);
		ev_write_q.delete();
		ev_addr_q.delete();
		wb_addr_q.delete();
		wb_block_q.delete();
		@(posedge clk);
		proc_req.read  <= ~wr;
		proc_req.write <= wr;
		proc_req.addr  <= a;
		proc_req.wdata <= d;
		@(negedge clk);
		// a hit never stalls, a miss stalls at once
		stalled = proc_stall;
		while (proc_stall) begin
			@(negedge clk);
		end
		got = proc_rdata;
		check_flag(stalled, exp_miss, $sformatf("stall in request cycle, word %h", a));
		check_flag(ev_addr_q.size() == exp_n, 1'b1, "number of memory requests");
		check_flag(wb_addr_q.size() == int'(exp_wb), 1'b1, "number of write-backs");
		if (exp_wb) begin
			check_flag(ev_write_q[0], 1'b1, "write-back comes before the fill");
			check_addr(ev_addr_q[0], victim, "write-back request address");
			check_addr(wb_addr_q[0], victim, "write-back address at memory");
			check_block(wb_block_q[0], victim_data, "write-back block");
		end
		if (exp_miss) begin
			check_flag(ev_write_q[exp_n-1], 1'b0, "fill request is a read");
			check_addr(ev_addr_q[exp_n-1], a[WORD_ADDR_W-1:WORD_OFS_W], "fill address");
		end
		if (wr) begin
			shadow[int'(a)] = d;
		end else begin
			check_word(got, expected_word(a), $sformatf("read data at word %h", a));
		end
	endtask

	task automatic run_random();
		int         blk_n;
		int         ofs;
		logic       wr;
		word_t      d;
		for (int i = 0; i < N_RANDOM; i++) begin
			// 16 blocks over four sets keeps evictions frequent
			blk_n = {$random(seed)} % 16;
			ofs   = {$random(seed)} % WORDS_PER_BLOCK;
			wr    = 1'({$random(seed)} % 2);
			d     = $random(seed);
			run_op(wr, word_addr_t'(blk_n * WORDS_PER_BLOCK + ofs), d);
		end
	endtask

	initial begin
		proc_reset = 1'b1;
		proc_req   = '0;
		for (int w = 0; w < MEM_WORDS; w++) begin
			shadow[w] = init_word(w);
		end
		for (int b = 0; b < MEM_BLOCKS; b++) begin
			mem_i.store[b] <= init_block(b);
		end
		for (int s = 0; s < NUM_SETS; s++) begin
			ref_lru[s] = 1'b0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				ref_valid[w][s] = 1'b0;
				ref_dirty[w][s] = 1'b0;
				ref_blk[w][s]   = '0;
			end
		end
		repeat (4) @(posedge clk);
		proc_reset <= 1'b0;
		// idle cycle out of reset
		@(negedge clk);
		check_flag(proc_stall, 1'b1, "stall right after reset");
		check_flag(mem_req.read, 1'b0, "mem read right after reset");
		check_flag(mem_req.write, 1'b0, "mem write right after reset");
		// cold miss, then a hit in the same block
		run_op(1'b0, 30'h5, '0);
		run_op(1'b0, 30'h6, '0);
		// write hit, then the whole block back
		run_op(1'b1, 30'h4, 32'hDEAD_BEEF);
		for (int i = 4; i < 8; i++) begin
			run_op(1'b0, word_addr_t'(i), '0);
		end
		// blocks 1, 5, 9 and 13 share set 1; block 1 is dirty
		run_op(1'b0, 30'h14, '0);
		run_op(1'b0, 30'h25, '0);
		// clean victim, block 5
		run_op(1'b0, 30'h36, '0);
		run_random();
		@(posedge clk);
		proc_req <= '0;
		repeat (2) @(posedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/dcache_tb_mem.sv ====
// memory model: MEM_BLOCKS blocks indexed by low address bits only; the testbench preloads it
`timescale 1ns/100ps
`default_nettype none

module dcache_tb_mem #(
	parameter int MEM_BLOCKS = 64,
	parameter int SEED       = 21
) (
	input  logic                    clk,
	input  logic                    proc_reset,
	input  dcache_pkg::mem_req_t    mem_req,
	output dcache_pkg::block_t      mem_rdata,
	output logic                    mem_ready,
	output logic                    wb_valid,
	output dcache_pkg::block_addr_t wb_addr,
	output dcache_pkg::block_t      wb_block
);
	import dcache_pkg::*;

	localparam int IDX_W = $clog2(MEM_BLOCKS);

	// contents, loaded from the testbench at time zero
	block_t           store [MEM_BLOCKS];
	int               seed = SEED;
	logic             busy;
	logic [3:0]       wait_cnt;
	logic [IDX_W-1:0] idx;

	assign idx = mem_req.addr[IDX_W-1:0];

	// ------------------------------
	// request handling
	// ------------------------------
	always @(posedge clk) begin
		// ready and log strobe are single-cycle pulses
		mem_ready <= 1'b0;
		wb_valid  <= 1'b0;
		if (proc_reset) begin
			busy      <= 1'b0;
			wait_cnt  <= 4'd0;
			mem_rdata <= '0;
			wb_addr   <= '0;
			wb_block  <= '0;
		end else if (mem_ready) begin
			// cache drops its strobe in the ready cycle
			busy <= 1'b0;
		end else if (!busy && (mem_req.read || mem_req.write)) begin
			busy     <= 1'b1;
			// 1 to 8 cycles until ready
			wait_cnt <= 4'({$random(seed)} % 8);
		end else if (busy) begin
			if (wait_cnt == 4'd0) begin
				mem_ready <= 1'b1;
				if (mem_req.read) begin
					mem_rdata <= store[idx];
				end
				if (mem_req.write) begin
					store[idx] <= mem_req.wdata;
					// write-back log for the testbench
					wb_valid <= 1'b1;
					wb_addr  <= mem_req.addr;
					wb_block <= mem_req.wdata;
				end
			end else begin
				wait_cnt <= wait_cnt - 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/dcache_ctrl.sv ====
// one request in flight; the processor request must hold steady while proc_stall is high
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl (
	input  logic                    clk,
	input  logic                    proc_reset,
	input  logic                    proc_read,
	input  logic                    proc_write,
	input  dcache_pkg::block_addr_t req_block,
	input  dcache_pkg::lookup_t     lookup,
	input  dcache_pkg::block_t      victim_block,
	input  logic                    mem_ready,
	output logic                    proc_stall,
	output dcache_pkg::mem_req_t    mem_req,
	output logic                    fill_en,
	output logic                    write_hit_en,
	output logic                    touch_en,
	output dcache_pkg::way_t        fill_way
);
	import dcache_pkg::*;

	cache_state_t state;
	cache_state_t state_nxt;
	way_t         victim_way_q;
	logic         req_valid;
	logic         miss;

	assign req_valid = proc_read | proc_write;
	// only meaningful in ST_COMPARE
	assign miss      = req_valid & ~lookup.hit;

	// ------------------------------
	// state and victim register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state        <= ST_IDLE;
			victim_way_q <= 1'b0;
		end else begin
			state <= state_nxt;
			// capture victim at miss time, fill lands in the same way
			if (state == ST_COMPARE && miss) begin
				victim_way_q <= lookup.victim_way;
			end
		end
	end

	assign fill_way = victim_way_q;

	// ------------------------------
	// next state and outputs
	// ------------------------------
	always_comb begin
		state_nxt     = state;
		proc_stall    = 1'b1;
		mem_req       = '0;
		mem_req.addr  = req_block;
		fill_en       = 1'b0;
		write_hit_en  = 1'b0;
		touch_en      = 1'b0;
		case (state)
			ST_IDLE: begin
				// one stalled cycle out of reset
				state_nxt = ST_COMPARE;
			end
			ST_COMPARE: begin
				// hit or no request costs nothing
				proc_stall = miss;
				if (req_valid && lookup.hit) begin
					touch_en     = proc_read;
					write_hit_en = proc_write;
				end
				if (miss) begin
					// dirty victim must reach memory first
					state_nxt = lookup.victim_dirty ? ST_WRITE_BACK : ST_ALLOCATE;
				end
			end
			ST_WRITE_BACK: begin
				// strobe drops in the ready cycle
				mem_req.write = ~mem_ready;
				mem_req.addr  = lookup.victim_addr;
				mem_req.wdata = victim_block;
				if (mem_ready) begin
					state_nxt = ST_ALLOCATE;
				end
			end
			ST_ALLOCATE: begin
				mem_req.read = ~mem_ready;
				// mem_rdata valid with the ready pulse
				if (mem_ready) begin
					fill_en   = 1'b1;
					state_nxt = ST_COMPARE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	// ------------------------------
	// checks
	// ------------------------------
	// memory strobes are exclusive
	a_mem_strobe_excl: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write));

	// a pending memory phase keeps its block address until mem_ready
	a_mem_addr_hold: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_req.read || mem_req.write) && !mem_ready |=> $stable(mem_req.addr));

endmodule

`default_nettype wire

// ==== src/dcache_data_store.sv ====
// block contents are undefined until filled; word 0 sits in the low 32 bits of a block
`timescale 1ns/100ps
`default_nettype none

module dcache_data_store #(
	parameter int SET_BITS = 2
) (
	input  logic                   clk,
	input  dcache_pkg::word_addr_t addr,
	input  dcache_pkg::way_t       hit_way,
	input  dcache_pkg::way_t       fill_way,
	input  logic                   fill_en,
	input  logic                   write_hit_en,
	input  dcache_pkg::word_t      wdata,
	input  dcache_pkg::block_t     mem_rdata,
	output dcache_pkg::word_t      rd_word,
	input  dcache_pkg::way_t       victim_way,
	output dcache_pkg::block_t     victim_block
);
	import dcache_pkg::*;

	localparam int NUM_SETS = 1 << SET_BITS;

	typedef logic [SET_BITS-1:0]   set_t;
	typedef logic [WORD_OFS_W-1:0] ofs_t;
	// word view of one block
	typedef word_t [WORDS_PER_BLOCK-1:0] block_words_t;

	block_t       blocks [NUM_WAYS][NUM_SETS];

	set_t         set_idx;
	ofs_t         word_ofs;
	block_words_t hit_words;
	block_words_t merged_words;

	assign set_idx  = addr[WORD_OFS_W +: SET_BITS];
	assign word_ofs = addr[WORD_OFS_W-1:0];

	// ------------------------------
	// read side
	// ------------------------------
	assign hit_words    = block_words_t'(blocks[hit_way][set_idx]);
	// meaningless on a miss while the processor is stalled
	assign rd_word      = hit_words[word_ofs];
	assign victim_block = blocks[victim_way][set_idx];

	// write hit replaces one word and keeps the rest of the block
	always_comb begin
		merged_words           = hit_words;
		merged_words[word_ofs] = wdata;
	end

	// ------------------------------
	// write side
	// ------------------------------
	always_ff @(posedge clk) begin
		if (fill_en) begin
			// whole block from memory
			blocks[fill_way][set_idx] <= mem_rdata;
		end else if (write_hit_en) begin
			blocks[hit_way][set_idx] <= block_t'(merged_words);
		end
	end

endmodule

`default_nettype wire

// ==== src/dcache_pkg.sv ====
// fixed geometry: 32-bit words, four-word blocks, two ways; only the set count varies
`default_nettype none

package dcache_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int WORD_W          = 32;
	localparam int WORDS_PER_BLOCK = 4;
	localparam int WORD_OFS_W      = 2;
	localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;
	localparam int WORD_ADDR_W     = 30;
	// block address drops the word offset
	localparam int BLOCK_ADDR_W    = WORD_ADDR_W - WORD_OFS_W;
	localparam int NUM_WAYS        = 2;

	typedef logic [WORD_W-1:0]       word_t;
	typedef logic [BLOCK_W-1:0]      block_t;
	typedef logic [WORD_ADDR_W-1:0]  word_addr_t;
	typedef logic [BLOCK_ADDR_W-1:0] block_addr_t;
	// one bit is enough for two ways
	typedef logic                    way_t;

	// ------------------------------
	// port bundles
	// ------------------------------
	// processor side, held steady while stalled
	typedef struct packed {
		logic       read;
		logic       write;
		word_addr_t addr;
		word_t      wdata;
	} proc_req_t;

	// memory side, level strobes until mem_ready
	typedef struct packed {
		logic        read;
		logic        write;
		block_addr_t addr;
		block_t      wdata;
	} mem_req_t;

	// tag store result for the current address
	typedef struct packed {
		logic        hit;
		way_t        hit_way;
		way_t        victim_way;
		logic        victim_dirty;
		block_addr_t victim_addr;
	} lookup_t;

	// controller states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_COMPARE,
		ST_WRITE_BACK,
		ST_ALLOCATE
	} cache_state_t;

endpackage

`default_nettype wire

// ==== src/dcache_tag_store.sv ====
// lines reset invalid; LRU bit per set names the victim, fills and hits move it away
`timescale 1ns/100ps
`default_nettype none

module dcache_tag_store #(
	parameter int SET_BITS = 2
) (
	input  logic                   clk,
	input  logic                   proc_reset,
	input  dcache_pkg::word_addr_t addr,
	input  logic                   fill_en,
	input  logic                   write_hit_en,
	input  logic                   touch_en,
	input  dcache_pkg::way_t       fill_way,
	output dcache_pkg::lookup_t    lookup
);
	import dcache_pkg::*;

	localparam int NUM_SETS = 1 << SET_BITS;
	// 26 bits at four sets
	localparam int TAG_W    = BLOCK_ADDR_W - SET_BITS;

	typedef logic [SET_BITS-1:0] set_t;
	typedef logic [TAG_W-1:0]    tag_t;

	tag_t                tag_q   [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
	logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];
	// 0 names way 0 as next victim
	logic [NUM_SETS-1:0] lru_q;

	set_t                set_idx;
	tag_t                req_tag;
	logic [NUM_WAYS-1:0] way_hit;
	way_t                hit_way;
	way_t                victim_way;

	// address split: tag | set | word offset
	assign set_idx = addr[WORD_OFS_W +: SET_BITS];
	assign req_tag = addr[WORD_ADDR_W-1 -: TAG_W];

	// ------------------------------
	// lookup
	// ------------------------------
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = valid_q[w][set_idx] && (tag_q[w][set_idx] == req_tag);
		end
	end

	// two ways, so way 1 hit picks way 1
	assign hit_way    = way_hit[1];
	assign victim_way = lru_q[set_idx];

	always_comb begin
		lookup              = '0;
		lookup.hit          = |way_hit;
		lookup.hit_way      = hit_way;
		lookup.victim_way   = victim_way;
		lookup.victim_dirty = valid_q[victim_way][set_idx] & dirty_q[victim_way][set_idx];
		// rebuild the victim block address from its stored tag
		lookup.victim_addr  = {tag_q[victim_way][set_idx], set_idx};
	end

	// ------------------------------
	// updates
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			lru_q <= '0;
		end else if (fill_en) begin
			// fresh line is clean
			valid_q[fill_way][set_idx] <= 1'b1;
			dirty_q[fill_way][set_idx] <= 1'b0;
			lru_q[set_idx]             <= ~fill_way;
		end else if (write_hit_en || touch_en) begin
			if (write_hit_en) begin
				dirty_q[hit_way][set_idx] <= 1'b1;
			end
			lru_q[set_idx] <= ~hit_way;
		end
	end

	// tag written on fill only
	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_q[fill_way][set_idx] <= req_tag;
		end
	end

	// a block lives in at most one way of its set
	a_single_hit: assert property (@(posedge clk) disable iff (proc_reset)
		!(&way_hit));

endmodule

`default_nettype wire

// ==== src/dcache_top.sv ====
// word-addressed processor port, block-wide memory port; SET_BITS is the only knob
`timescale 1ns/100ps
`default_nettype none

module dcache_top #(
	parameter int SET_BITS = 2
) (
	input  logic                  clk,
	input  logic                  proc_reset,
	input  dcache_pkg::proc_req_t proc_req,
	output dcache_pkg::word_t     proc_rdata,
	output logic                  proc_stall,
	output dcache_pkg::mem_req_t  mem_req,
	input  dcache_pkg::block_t    mem_rdata,
	input  logic                  mem_ready
);
	import dcache_pkg::*;

	// ------------------------------
	// internal nets
	// ------------------------------
	lookup_t lookup;
	block_t  victim_block;
	logic    fill_en;
	logic    write_hit_en;
	logic    touch_en;
	way_t    fill_way;

	// sequencing, hit/miss decision
	dcache_ctrl ctrl_i (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_req.read),
		.proc_write   (proc_req.write),
		.req_block    (proc_req.addr[WORD_ADDR_W-1:WORD_OFS_W]),
		.lookup       (lookup),
		.victim_block (victim_block),
		.mem_ready    (mem_ready),
		.proc_stall   (proc_stall),
		.mem_req      (mem_req),
		.fill_en      (fill_en),
		.write_hit_en (write_hit_en),
		.touch_en     (touch_en),
		.fill_way     (fill_way)
	);

	// tags, valid, dirty, lru
	dcache_tag_store #(
		.SET_BITS (SET_BITS)
	) tag_store_i (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.addr         (proc_req.addr),
		.fill_en      (fill_en),
		.write_hit_en (write_hit_en),
		.touch_en     (touch_en),
		.fill_way     (fill_way),
		.lookup       (lookup)
	);

	// block array, word read straight to the processor
	dcache_data_store #(
		.SET_BITS (SET_BITS)
	) data_store_i (
		.clk          (clk),
		.addr         (proc_req.addr),
		.hit_way      (lookup.hit_way),
		.fill_way     (fill_way),
		.fill_en      (fill_en),
		.write_hit_en (write_hit_en),
		.wdata        (proc_req.wdata),
		.mem_rdata    (mem_rdata),
		.rd_word      (proc_rdata),
		.victim_way   (lookup.victim_way),
		.victim_block (victim_block)
	);

endmodule

`default_nettype wire
